/* compile.f */
+incdir+.
ssm_pkg.sv
ssm_flow_ctrl.sv
ssm_discretize.sv
ssm_state_update.sv
ssm_group_accum.sv
ssm_block_top.sv
tb_ssm_block.sv

/* ssm_block_top.sv */
// ====================
// ssm head datapath top
// flow ctrl -> discretize -> state update -> group accum
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_block_top #(
    parameter int TILES_PER_GROUP = 4,  // N_TOTAL = TILES_PER_GROUP * N_TILE
    parameter int Y_CREDITS       = 2   // result slots in the consumer
) (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      tile_valid_i,
    input  wire ssm_pkg::tile_in_t   tile_i,
    output logic                     tile_ready_o,
    input  wire                      credit_i,
    output ssm_pkg::p_vec_t          y_o,
    output logic                     y_valid_o
);
    import ssm_pkg::*;

    logic     accept;       // tile handshake
    grp_tag_t tag;
    logic     disc_valid;
    disc_t    disc;
    logic     part_valid;
    partial_t part;

    ssm_flow_ctrl #(
        .TILES_PER_GROUP (TILES_PER_GROUP),
        .Y_CREDITS       (Y_CREDITS)
    ) u_flow_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .credit_i     (credit_i),
        .tile_ready_o (tile_ready_o),
        .accept_o     (accept),
        .tag_o        (tag)
    );

    ssm_discretize u_discretize (
        .clk     (clk),
        .rstn    (rstn),
        .valid_i (accept),
        .tile_i  (tile_i),
        .tag_i   (tag),
        .valid_o (disc_valid),
        .disc_o  (disc)
    );

    ssm_state_update u_state_update (
        .clk     (clk),
        .rstn    (rstn),
        .valid_i (disc_valid),
        .disc_i  (disc),
        .valid_o (part_valid),
        .part_o  (part)
    );

    ssm_group_accum u_group_accum (
        .clk       (clk),
        .rstn      (rstn),
        .valid_i   (part_valid),
        .part_i    (part),
        .y_o       (y_o),
        .y_valid_o (y_valid_o)
    );

endmodule

`default_nettype wire

/* ssm_discretize.sv */
// ====================
// step-size discretization, two register stages
// s1: delta = max(dt + dt_bias, 0)
// s2: dA = 1 + delta*A, dx = delta*x, xD = x*D
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_discretize (
    input  wire               clk,
    input  wire               rstn,
    input  wire               valid_i,
    input  wire ssm_pkg::tile_in_t tile_i,
    input  wire ssm_pkg::grp_tag_t tag_i,
    output logic              valid_o,
    output ssm_pkg::disc_t    disc_o
);
    import ssm_pkg::*;

    fx_t      dt_sum;     // wraps at DW
    fx_t      delta_d;

    // stage 1 regs
    logic     s1_valid_q;
    fx_t      s1_delta_q;
    fx_t      s1_a_q;
    fx_t      s1_d_q;
    p_vec_t   s1_x_q;
    n_vec_t   s1_b_q;
    n_vec_t   s1_c_q;
    pn_vec_t  s1_hprev_q;
    grp_tag_t s1_tag_q;

    assign dt_sum  = tile_i.dt + tile_i.dt_bias;
    assign delta_d = dt_sum[DW-1] ? '0 : dt_sum;  // zero clamp stands in for softplus

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid_q <= 1'b0;
            valid_o    <= 1'b0;
        end else begin
            s1_valid_q <= valid_i;
            valid_o    <= s1_valid_q;
        end
    end

    // ==================== stage 1
    always_ff @(posedge clk) begin
        if (valid_i) begin
            s1_delta_q <= delta_d;
            s1_a_q     <= tile_i.A;
            s1_d_q     <= tile_i.D;
            s1_x_q     <= tile_i.x;
            s1_b_q     <= tile_i.B;
            s1_c_q     <= tile_i.C;
            s1_hprev_q <= tile_i.hprev;
            s1_tag_q   <= tag_i;
        end
    end

    // ==================== stage 2
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            disc_o.dA <= FX_ONE + fx_mul(s1_delta_q, s1_a_q);  // first-order exp
            for (int p = 0; p < P_TILE; p++) begin
                disc_o.dx[p] <= fx_mul(s1_delta_q, s1_x_q[p]);
                disc_o.xD[p] <= fx_mul(s1_x_q[p], s1_d_q);     // skip term
            end
            disc_o.B     <= s1_b_q;   // pass through in step
            disc_o.C     <= s1_c_q;
            disc_o.hprev <= s1_hprev_q;
            disc_o.tag   <= s1_tag_q;
        end
    end

endmodule

`default_nettype wire

/* ssm_flow_ctrl.sv */
// ====================
// tile acceptance and group tagging
// output credit counter gates the start of each group
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_flow_ctrl #(
    parameter int TILES_PER_GROUP = 4,
    parameter int Y_CREDITS       = 2
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               tile_valid_i,
    input  wire               credit_i,     // consumer freed one result slot
    output logic              tile_ready_o,
    output logic              accept_o,     // tile transfers this cycle
    output ssm_pkg::grp_tag_t tag_o
);
    import ssm_pkg::*;

    localparam int CNT_W = (TILES_PER_GROUP > 1) ? $clog2(TILES_PER_GROUP) : 1;
    localparam int CRD_W = $clog2(Y_CREDITS + 1);

    grp_state_e       state_q;
    logic [CNT_W-1:0] tile_cnt_q;  // tiles accepted in current group
    logic [CRD_W-1:0] credit_q;    // free result slots downstream
    logic             grp_start;

    // a running group never stalls, only a new one waits for a credit
    assign tile_ready_o = (state_q == RUN) || (credit_q != '0);
    assign accept_o     = tile_valid_i && tile_ready_o;

    assign tag_o.first = (state_q == IDLE);
    assign tag_o.last  = (tile_cnt_q == CNT_W'(TILES_PER_GROUP - 1));
    assign grp_start   = accept_o && tag_o.first;

    // ==================== group position
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q    <= IDLE;
            tile_cnt_q <= '0;
        end else if (accept_o) begin
            if (tag_o.last) begin
                state_q    <= IDLE;  // group done
                tile_cnt_q <= '0;
            end else begin
                state_q    <= RUN;
                tile_cnt_q <= tile_cnt_q + 1'b1;
            end
        end
    end

    // ==================== credits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_q <= CRD_W'(Y_CREDITS);
        end else if (grp_start && !credit_i) begin
            credit_q <= credit_q - 1'b1;  // slot reserved for this group
        end else if (credit_i && !grp_start) begin
            credit_q <= credit_q + 1'b1;
        end
        // start and return in the same cycle cancel out
    end

endmodule

`default_nettype wire

/* ssm_group_accum.sv */
// ====================
// running sum of tile partials over a group
// adds xD of the last tile and registers y
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_group_accum (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  valid_i,
    input  wire ssm_pkg::partial_t part_i,
    output ssm_pkg::p_vec_t      y_o,
    output logic                 y_valid_o
);
    import ssm_pkg::*;

    p_vec_t run_sum_q;  // sum of earlier tiles in this group
    p_vec_t sum_d;      // running sum including the incoming tile
    p_vec_t y_d;

    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            // first tile drops whatever the previous group left behind
            sum_d[p] = (part_i.tag.first ? fx_t'(0) : run_sum_q[p]) + part_i.y_part[p];
            y_d[p]   = sum_d[p] + part_i.xD[p];  // skip term, last tile only
        end
    end

    // ==================== result pulse
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            y_valid_o <= 1'b0;
        end else begin
            y_valid_o <= valid_i && part_i.tag.last;  // one cycle per group
        end
    end

    // ==================== data regs
    always_ff @(posedge clk) begin
        if (valid_i) begin
            run_sum_q <= sum_d;
            if (part_i.tag.last) begin
                y_o <= y_d;  // held until the next group ends
            end
        end
    end

endmodule

`default_nettype wire

/* ssm_pkg.sv */
// ====================
// shared package for the ssm head datapath
// q8.8 constants, lane counts, fx product helper
// packed structs for tile, stage and partial buses, flow-ctrl enum
// ====================
`default_nettype none

package ssm_pkg;

    localparam int DW        = 16;   // data width
    localparam int FRAC_BITS = 8;    // q8.8
    localparam int P_TILE    = 2;    // output lanes
    localparam int N_TILE    = 4;    // state lanes per tile

    typedef logic signed [DW-1:0] fx_t;

    localparam fx_t FX_ONE = fx_t'(1 << FRAC_BITS);  // 1.0 = 256

    typedef fx_t    [P_TILE-1:0] p_vec_t;
    typedef fx_t    [N_TILE-1:0] n_vec_t;
    typedef n_vec_t [P_TILE-1:0] pn_vec_t;  // indexed [p][n]

    typedef struct packed {
        fx_t     dt;
        fx_t     dt_bias;
        fx_t     A;
        fx_t     D;
        p_vec_t  x;
        n_vec_t  B;
        n_vec_t  C;
        pn_vec_t hprev;
    } tile_in_t;

    typedef struct packed {
        logic first;  // first tile of its group
        logic last;   // last tile of its group
    } grp_tag_t;

    typedef struct packed {
        fx_t      dA;
        p_vec_t   dx;
        p_vec_t   xD;
        n_vec_t   B;
        n_vec_t   C;
        pn_vec_t  hprev;
        grp_tag_t tag;
    } disc_t;

    typedef struct packed {
        p_vec_t   y_part;  // sum over n of h_next*C for this tile
        p_vec_t   xD;
        grp_tag_t tag;
    } partial_t;

    typedef enum logic {IDLE, RUN} grp_state_e;

    // full signed product, arithmetic shift by FRAC_BITS, truncate to DW
    function automatic fx_t fx_mul(fx_t a, fx_t b);
        logic signed [2*DW-1:0] prod;
        prod = a * b;
        return fx_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

/* ssm_state_update.sv */
// ====================
// hidden state update and C projection
// s1: h_next[p][n] = dA*hprev[p][n] + dx[p]*B[n]
// s2: y_part[p] = sum over n of h_next[p][n]*C[n]
// ====================
`timescale 1ns/1ps
`default_nettype none

module ssm_state_update (
    input  wire                clk,
    input  wire                rstn,
    input  wire                valid_i,
    input  wire ssm_pkg::disc_t disc_i,
    output logic               valid_o,
    output ssm_pkg::partial_t  part_o
);
    import ssm_pkg::*;

    pn_vec_t  h_next_d;
    p_vec_t   y_red_d;    // reduction over state lanes

    // stage 1 regs
    logic     s1_valid_q;
    pn_vec_t  s1_h_q;
    n_vec_t   s1_c_q;
    p_vec_t   s1_xd_q;
    grp_tag_t s1_tag_q;

    // dAh + dBx per lane
    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            for (int n = 0; n < N_TILE; n++) begin
                h_next_d[p][n] = fx_mul(disc_i.dA, disc_i.hprev[p][n])
                               + fx_mul(disc_i.dx[p], disc_i.B[n]);
            end
        end
    end

    // hC products folded into one sum per p lane, wraps at DW
    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            y_red_d[p] = '0;
            for (int n = 0; n < N_TILE; n++) begin
                y_red_d[p] = y_red_d[p] + fx_mul(s1_h_q[p][n], s1_c_q[n]);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid_q <= 1'b0;
            valid_o    <= 1'b0;
        end else begin
            s1_valid_q <= valid_i;
            valid_o    <= s1_valid_q;
        end
    end

    // ==================== stage 1
    always_ff @(posedge clk) begin
        if (valid_i) begin
            s1_h_q   <= h_next_d;    // h_next stays internal
            s1_c_q   <= disc_i.C;
            s1_xd_q  <= disc_i.xD;
            s1_tag_q <= disc_i.tag;
        end
    end

    // ==================== stage 2
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            part_o.y_part <= y_red_d;
            part_o.xD     <= s1_xd_q;
            part_o.tag    <= s1_tag_q;
        end
    end

endmodule

`default_nettype wire

/* tb_ssm_ref.svh */
// ====================
// testbench helpers
// galois lfsr, reference model for one group of tiles
// compare tasks for y, tile ready and result latency
// ====================
`ifndef TB_SSM_REF_SVH
`define TB_SSM_REF_SVH

    // one lfsr step per bit taken, taps 16'hB400
    function automatic logic [15:0] take_bits(inout logic [15:0] s, input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], s[0]};
            s = (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    // q8.8 product: full signed product, >>> 8, keep 16 bits
    function automatic fx_t q_mul(input fx_t a, input fx_t b);
        logic signed [31:0] full;
        full = $signed(a) * $signed(b);
        return full[23:8];
    endfunction

    // expected y for a whole group, sums wrap at 16 bits
    function automatic p_vec_t ref_group(input tile_in_t g[$]);
        p_vec_t   y;
        tile_in_t t;
        fx_t      delta;
        fx_t      da;
        fx_t      dx;
        fx_t      h;
        fx_t      acc;
        y = '0;
        foreach (g[i]) begin
            t     = g[i];
            delta = t.dt + t.dt_bias;
            if (delta < 0) delta = '0;                // clamp in place of softplus
            da = fx_t'(256) + q_mul(delta, t.A);      // 1 + delta*A
            for (int p = 0; p < P_TILE; p++) begin
                dx  = q_mul(delta, t.x[p]);
                acc = '0;
                for (int n = 0; n < N_TILE; n++) begin
                    h   = q_mul(da, t.hprev[p][n]) + q_mul(dx, t.B[n]);
                    acc = acc + q_mul(h, t.C[n]);
                end
                y[p] = y[p] + acc;
            end
        end
        t = g[g.size() - 1];
        for (int p = 0; p < P_TILE; p++) begin
            y[p] = y[p] + q_mul(t.x[p], t.D);       // skip term of the last tile
        end
        return y;
    endfunction

    task automatic check_y(input p_vec_t got, input p_vec_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: y_o = %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: tile_ready_o = %b, expected %b",
                               $time, got, exp));
        end
    endtask

    task automatic check_cycle(input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("Error at %0t: y_valid_o in cycle %0d, expected cycle %0d",
                               $time, got, exp));
        end
    endtask

`endif

/* tb_ssm_block.sv */
// ====================
// testbench for the ssm head datapath
// stimulus, credit-returning consumer, result and ready checks, timeout
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_ssm_block;
    import ssm_pkg::*;

    localparam int TPG           = 4;
    localparam int CREDITS       = 2;
    localparam int N_GROUPS      = 1 + 8 + 1 + CREDITS + 1 + 4;  // over all tests
    localparam int MAX_GAP       = 3;
    localparam int TIMEOUT       = N_GROUPS * TPG * (MAX_GAP + 1) + N_GROUPS * 8 + 50;
    localparam int MODE_RAND     = 0;
    localparam int MODE_CONST_XD = 1;
    localparam int MODE_NEG_DT   = 2;

    logic        clk;
    logic        rstn;
    logic        tile_valid_i;
    tile_in_t    tile_i;
    logic        tile_ready_o;
    logic        credit_i;
    p_vec_t      y_o;
    logic        y_valid_o;

    logic [15:0] stim_lfsr    = 16'd82;  // tile values and gaps
    logic [15:0] cons_lfsr    = 16'd82;  // consumer credit delays
    int          cyc          = 0;
    int          exp_credits  = CREDITS;
    logic        hold_credits = 1'b0;
    logic        fast_credits = 1'b0;
    tile_in_t    grp_tiles[$];           // accepted tiles of the open group
    p_vec_t      exp_y_q[$];
    int          exp_cyc_q[$];
    int          due_q[$];               // cycles at which credits go back

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first failure");
    endtask

    `include "tb_ssm_ref.svh"

    ssm_block_top #(
        .TILES_PER_GROUP (TPG),
        .Y_CREDITS       (CREDITS)
    ) dut (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .tile_i       (tile_i),
        .tile_ready_o (tile_ready_o),
        .credit_i     (credit_i),
        .y_o          (y_o),
        .y_valid_o    (y_valid_o)
    );

    always #4 clk = ~clk;  // 8 ns period

    // ==================== stimulus helpers
    function automatic fx_t rand_fx(input int bits);
        fx_t v;
        v = fx_t'(take_bits(stim_lfsr, bits) << (16 - bits));
        return v >>> (16 - bits);  // sign-extend from top bit taken
    endfunction

    function automatic tile_in_t make_tile(input int mode);
        tile_in_t t;
        t.dt      = rand_fx(7);  // +-0.25
        t.dt_bias = rand_fx(7);
        t.A       = rand_fx(9);  // +-1.0
        t.D       = rand_fx(9);
        for (int p = 0; p < P_TILE; p++) t.x[p] = rand_fx(9);
        for (int n = 0; n < N_TILE; n++) begin
            t.B[n] = rand_fx(9);
            t.C[n] = rand_fx(9);
        end
        for (int p = 0; p < P_TILE; p++) begin
            for (int n = 0; n < N_TILE; n++) t.hprev[p][n] = rand_fx(9);
        end
        if (mode == MODE_CONST_XD) begin
            for (int p = 0; p < P_TILE; p++) t.x[p] = fx_t'(256);  // 1.0
            t.D = fx_t'(128);                                     // 0.5
        end
        if (mode == MODE_NEG_DT) begin
            t.dt      = -fx_t'(64) - fx_t'(take_bits(stim_lfsr, 8));  // -0.25 .. -1.25
            t.dt_bias = fx_t'(take_bits(stim_lfsr, 6));               // below 0.25
        end
        return t;
    endfunction

    // ready cannot change between a falling edge and the next rising edge
    task automatic send_tile(input tile_in_t t);
        tile_valid_i = 1'b1;
        tile_i       = t;
        while (!tile_ready_o) @(negedge clk);
        @(negedge clk);
        tile_valid_i = 1'b0;
    endtask

    task automatic send_group(input int mode, input bit gaps);
        for (int i = 0; i < TPG; i++) begin
            send_tile(make_tile(mode));
            if (gaps) repeat (take_bits(stim_lfsr, 2)) @(negedge clk);  // 0..MAX_GAP idle
        end
    endtask

    task automatic wait_idle();
        while (exp_y_q.size() != 0 || due_q.size() != 0 || credit_i) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // ==================== accept monitor and timeout
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > TIMEOUT) begin
            stop_run($sformatf("timeout: tests did not finish within %0d cycles", TIMEOUT));
        end else if (rstn) begin
            if (credit_i) exp_credits = exp_credits + 1;
            if (tile_valid_i && tile_ready_o) begin
                if (grp_tiles.size() == 0) exp_credits = exp_credits - 1;  // group start
                grp_tiles.push_back(tile_i);
                if (grp_tiles.size() == TPG) begin
                    exp_y_q.push_back(ref_group(grp_tiles));
                    exp_cyc_q.push_back(cyc + 4);  // consumer samples it on edge +5
                    grp_tiles.delete();
                end
            end
        end
    end

    // ==================== compare and consumer
    always @(negedge clk) begin
        if (rstn) begin
            check_ready(tile_ready_o, (grp_tiles.size() != 0) || (exp_credits > 0));
            if (y_valid_o && exp_y_q.size() == 0) begin
                stop_run("y_valid_o pulsed while no group result was outstanding");
            end else if (y_valid_o) begin
                check_cycle(cyc, exp_cyc_q.pop_front());
                check_y(y_o, exp_y_q.pop_front());
                due_q.push_back(fast_credits ? cyc : cyc + int'(take_bits(cons_lfsr, 3)));
            end
            credit_i = 1'b0;
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cyc) begin
                credit_i = 1'b1;  // one slot freed
                void'(due_q.pop_front());
            end
        end
    end

    // ==================== test sequence
    initial begin
        tile_in_t held;  // tile offered while the group start is stalled

        clk          = 1'b0;
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        tile_i       = '0;
        credit_i     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        send_group(MODE_CONST_XD, 1'b0);  // single group with constant x and D
        wait_idle();
        fast_credits = 1'b1;
        repeat (8) send_group(MODE_RAND, 1'b0);  // back to back
        wait_idle();
        fast_credits = 1'b0;
        send_group(MODE_NEG_DT, 1'b0);  // delta clamped to zero
        wait_idle();

        // next group stalls at its first tile while credits are withheld
        hold_credits = 1'b1;
        repeat (CREDITS) send_group(MODE_RAND, 1'b0);
        while (exp_y_q.size() != 0) @(negedge clk);
        held         = make_tile(MODE_RAND);
        tile_valid_i = 1'b1;
        tile_i       = held;
        repeat (4) begin
            check_ready(tile_ready_o, 1'b0);
            @(negedge clk);
        end
        hold_credits = 1'b0;
        send_tile(held);  // stalled tile goes in once a credit is back
        for (int i = 1; i < TPG; i++) begin
            send_tile(make_tile(MODE_RAND));
        end
        wait_idle();

        repeat (4) send_group(MODE_RAND, 1'b1);  // idle gaps inside and between groups
        repeat (8) @(negedge clk);  // last result is due on the 5th edge after its last tile

        if (exp_y_q.size() != 0) begin
            stop_run("run ended with group results still outstanding");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
